/* icache_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// request latch and controller FSM of the instruction cache
// owns enable and flush bookkeeping, memory requests and the miss pulse
//////////////////////////////////////////////////////////////////////
module icache_ctrl #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  input  logic                             flush_i,
  input  logic                             fetch_req_i,
  input  icache_pkg::fetch_addr_u          fetch_addr_i,
  input  logic [NUM_WAYS-1:0]              hit_i,
  input  logic                             all_valid_i,
  input  logic                             victim_hit_i,
  input  icache_pkg::line_t                victim_line_i,
  input  icache_pkg::line_t                evict_line_i,
  input  logic [icache_pkg::TAG_W-1:0]     evict_tag_i,
  input  logic                             mem_ack_i,
  input  icache_pkg::refill_t              mem_rtrn_i,
  output logic                             ready_o,
  output logic                             lookup_o,
  output logic [icache_pkg::INDEX_W-1:0]   index_o,
  output logic [icache_pkg::TAG_W-1:0]     tag_o,
  output logic [icache_pkg::OFFSET_W-1:0]  offset_o,
  output logic                             fill_o,
  output icache_pkg::line_t                fill_line_o,
  output logic                             flush_en_o,
  output logic                             victim_we_o,
  output icache_pkg::victim_entry_t        victim_wr_o,
  output logic                             fetch_valid_o,
  output logic [1:0]                       src_sel_o,
  output logic                             mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0]    mem_addr_o,
  output logic                             miss_o
);
  import icache_pkg::*;

  typedef enum logic [2:0] {FLUSH, IDLE, READ, VICTIM_SWAP, VICTIM_EVICT, MISS} state_e;

  state_e             state_d, state_q;
  fetch_addr_u        addr_d, addr_q;
  logic               cache_en_d, cache_en_q;
  logic               flush_d, flush_q;
  logic [INDEX_W-1:0] flush_cnt_q;
  logic               flush_done;
  logic               cache_hit;
  logic               victim_hit;

  ////////////////////////////////////////////////////////////////////
  // request latch and array addressing
  ////////////////////////////////////////////////////////////////////

  assign lookup_o = ready_o & fetch_req_i;
  assign addr_d = lookup_o ? fetch_addr_i : addr_q;

  // sweep counter during flush, else the index of the lookup in progress
  assign index_o = (state_q == FLUSH) ? flush_cnt_q : addr_d.fields.index;
  assign tag_o = addr_q.fields.tag;
  assign offset_o = addr_q.fields.offset;
  // flat view of the latched address, offset cleared for a whole line
  assign mem_addr_o = {addr_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  assign flush_en_o = (state_q == FLUSH);
  assign flush_done = (flush_cnt_q == INDEX_W'(NUM_SETS - 1));

  // a disabled cache never hits, not even in the victim buffer
  assign cache_hit = cache_en_q & (|hit_i);
  assign victim_hit = cache_en_q & victim_hit_i;

  // swap writes back whatever the replaced way held
  assign victim_wr_o = '{
    valid: (state_q == VICTIM_SWAP) ? all_valid_i : 1'b1,
    tag:   evict_tag_i,
    index: addr_q.fields.index,
    line:  evict_line_i
  };
  assign fill_line_o = (state_q == VICTIM_SWAP) ? victim_line_i : mem_rtrn_i.line;

  ////////////////////////////////////////////////////////////////////
  // controller FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    // switching off is immediate, switching on goes through FLUSH
    cache_en_d = cache_en_q & en_i;
    flush_d = flush_q | flush_i;
    ready_o = 1'b0;
    fill_o = 1'b0;
    victim_we_o = 1'b0;
    fetch_valid_o = 1'b0;
    src_sel_o = SRC_HIT;
    mem_req_o = 1'b0;
    miss_o = 1'b0;

    unique case (state_q)
      FLUSH: begin
        if (flush_done) begin
          state_d = IDLE;
          flush_d = 1'b0;
          cache_en_d = en_i;
        end
      end
      IDLE: begin
        if (flush_d || (en_i && !cache_en_q)) begin
          state_d = FLUSH;
        end else begin
          ready_o = 1'b1;
          if (fetch_req_i) begin
            state_d = READ;
          end
        end
      end
      READ: begin
        if (cache_hit) begin
          // word goes out, next request may enter the lookup
          fetch_valid_o = 1'b1;
          ready_o = !flush_d;
          state_d = (ready_o && fetch_req_i) ? READ : IDLE;
        end else if (victim_hit) begin
          state_d = VICTIM_SWAP;
        end else if (cache_en_q && all_valid_i) begin
          // full set, park the line about to be replaced
          victim_we_o = 1'b1;
          state_d = VICTIM_EVICT;
        end else begin
          // free way or disabled cache, straight to memory
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            miss_o = cache_en_q;
            state_d = MISS;
          end
        end
      end
      VICTIM_EVICT: begin
        mem_req_o = 1'b1;
        if (mem_ack_i) begin
          miss_o = cache_en_q;
          state_d = MISS;
        end
      end
      VICTIM_SWAP: begin
        // buffer line into the set, set line into the buffer
        fill_o = 1'b1;
        victim_we_o = 1'b1;
        fetch_valid_o = 1'b1;
        src_sel_o = SRC_VICTIM;
        state_d = IDLE;
      end
      MISS: begin
        if (mem_rtrn_i.valid) begin
          fetch_valid_o = 1'b1;
          src_sel_o = SRC_REFILL;
          fill_o = cache_en_q;
          state_d = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FLUSH;
      cache_en_q <= 1'b0;
      flush_q <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      cache_en_q <= cache_en_d;
      flush_q <= flush_d;
      flush_cnt_q <= (flush_en_o && !flush_done) ? flush_cnt_q + 1'b1 : '0;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
  end

  // refills start only after the previous word has left
  a_req_not_with_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $rose(mem_req_o) |-> !fetch_valid_o
  );

  a_state_legal : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q inside {FLUSH, IDLE, READ, VICTIM_SWAP, VICTIM_EVICT, MISS}
  );

endmodule

/* icache_data_array.sv */
//////////////////////////////////////////////////////////////////////
// line storage for every way, addressed by set index
//////////////////////////////////////////////////////////////////////
module icache_data_array #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                                clk_i,
  input  logic                                rd_i,
  input  logic [icache_pkg::INDEX_W-1:0]      index_i,
  input  logic                                we_i,
  input  logic [NUM_WAYS-1:0]                 way_oh_i,
  input  icache_pkg::line_t                   line_i,
  output icache_pkg::line_t [NUM_WAYS-1:0]    line_o
);
  import icache_pkg::*;

  line_t [NUM_WAYS-1:0] line_mem [NUM_SETS];

  always_ff @(posedge clk_i) begin
    // write touches the selected way only
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (we_i && way_oh_i[w]) begin
        line_mem[index_i][w] <= line_i;
      end
    end
    // all ways read in parallel, output holds otherwise
    if (rd_i) begin
      line_o <= line_mem[index_i];
    end
  end

endmodule

/* icache_fetch_out.sv */
//////////////////////////////////////////////////////////////////////
// picks the fetched word from the hit way, victim line or refill
//////////////////////////////////////////////////////////////////////
module icache_fetch_out #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic [NUM_WAYS-1:0]                hit_oh_i,
  input  icache_pkg::line_t [NUM_WAYS-1:0]   lines_i,
  input  icache_pkg::line_t                  victim_line_i,
  input  icache_pkg::line_t                  refill_line_i,
  input  logic [icache_pkg::OFFSET_W-1:0]    offset_i,
  input  logic [1:0]                         src_sel_i,
  output logic [icache_pkg::FETCH_W-1:0]     fetch_data_o
);
  import icache_pkg::*;

  localparam int WAY_W = $clog2(NUM_WAYS);

  logic [WAY_W-1:0] hit_idx;
  line_t            victim_q;
  line_t            sel_line;

  // hit vector to way number
  always_comb begin
    hit_idx = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_oh_i[w]) begin
        hit_idx = WAY_W'(w);
      end
    end
  end

  // buffer content as of the lookup, before the swap rewrites it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      victim_q <= '0;
    end else begin
      victim_q <= victim_line_i;
    end
  end

  always_comb begin
    unique case (src_sel_i)
      SRC_VICTIM: sel_line = victim_q;
      SRC_REFILL: sel_line = refill_line_i;
      default:    sel_line = lines_i[hit_idx];
    endcase
  end

  // byte offset bits 1:0 are dropped
  assign fetch_data_o = sel_line[offset_i[OFFSET_W-1:2] * FETCH_W +: FETCH_W];

endmodule

/* icache_pkg.sv */
//////////////////////////////////////////////////////////////////////
// geometry, address view and shared structs of the instruction cache
// imported by every block that handles addresses or cache lines
//////////////////////////////////////////////////////////////////////
package icache_pkg;

  ////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////

  // physical byte address
  localparam int ADDR_W = 32;
  // one instruction word
  localparam int FETCH_W = 32;
  // one cache line, four words
  localparam int LINE_W = 128;
  localparam int NUM_SETS = 16;
  // byte offset inside a line
  localparam int OFFSET_W = 4;
  localparam int INDEX_W = 4;
  // whatever is left above index and offset
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;
  // default associativity, the top level may override it
  localparam int NUM_WAYS_DEF = 4;

  // source of the returned word
  localparam logic [1:0] SRC_HIT = 2'd0;
  localparam logic [1:0] SRC_VICTIM = 2'd1;
  localparam logic [1:0] SRC_REFILL = 2'd2;

  ////////////////////////////////////////////////////////////////////
  // address view
  ////////////////////////////////////////////////////////////////////

  // field split used for array addressing and tag compare
  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } addr_fields_t;

  // same word seen flat on the ports, split inside the cache
  typedef union packed {
    logic [ADDR_W-1:0] addr;
    addr_fields_t      fields;
  } fetch_addr_u;

  ////////////////////////////////////////////////////////////////////
  // line payloads
  ////////////////////////////////////////////////////////////////////

  typedef logic [LINE_W-1:0] line_t;

  // evicted line with its line address
  typedef struct packed {
    logic               valid;
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    line_t              line;
  } victim_entry_t;

  // memory return, valid for one cycle
  typedef struct packed {
    logic  valid;
    line_t line;
  } refill_t;

endpackage

/* icache_replace.sv */
//////////////////////////////////////////////////////////////////////
// hit qualification and refill way choice
// lowest invalid way first, else a way picked by an 8 bit LFSR
//////////////////////////////////////////////////////////////////////
module icache_replace #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [NUM_WAYS-1:0]  valid_i,
  input  logic [NUM_WAYS-1:0]  hit_i,
  input  logic                 advance_i,
  output logic [NUM_WAYS-1:0]  hit_o,
  output logic                 all_valid_o,
  output logic [NUM_WAYS-1:0]  way_oh_o
);
  localparam int WAY_W = $clog2(NUM_WAYS);

  logic [7:0]          lfsr_q;
  logic [NUM_WAYS-1:0] inv;
  logic [NUM_WAYS-1:0] inv_oh;
  logic [NUM_WAYS-1:0] rnd_oh;

  // a tag match counts only on a valid way
  assign hit_o = hit_i & valid_i;

  assign all_valid_o = &valid_i;
  // isolate the lowest invalid way
  assign inv = ~valid_i;
  assign inv_oh = inv & (~inv + 1'b1);
  assign rnd_oh = NUM_WAYS'(1) << lfsr_q[WAY_W-1:0];
  assign way_oh_o = all_valid_o ? rnd_oh : inv_oh;

  // fibonacci LFSR, taps 8 6 5 4
  // steps only when a fill replaces a valid line
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= 8'hA5;
    end else if (advance_i && all_valid_o) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  a_way_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot(way_oh_o)
  );

endmodule

/* icache_tag_array.sv */
//////////////////////////////////////////////////////////////////////
// tag and valid storage for every way, registered read
// valid bits are cleared one set per cycle by the flush sweep
//////////////////////////////////////////////////////////////////////
module icache_tag_array #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        rd_i,
  input  logic [icache_pkg::INDEX_W-1:0]              index_i,
  input  logic                                        flush_en_i,
  input  logic [icache_pkg::INDEX_W-1:0]              flush_idx_i,
  input  logic                                        we_i,
  input  logic [NUM_WAYS-1:0]                         way_oh_i,
  input  logic [icache_pkg::TAG_W-1:0]                tag_i,
  output logic [NUM_WAYS-1:0][icache_pkg::TAG_W-1:0]  tag_o,
  output logic [NUM_WAYS-1:0]                         valid_o
);
  import icache_pkg::*;

  logic [NUM_WAYS-1:0][TAG_W-1:0] tag_mem [NUM_SETS];
  logic [NUM_WAYS-1:0]            valid_q [NUM_SETS];

  // tag words, only the filled way is written
  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (we_i && way_oh_i[w]) begin
        tag_mem[index_i][w] <= tag_i;
      end
    end
    if (rd_i) begin
      tag_o <= tag_mem[index_i];
    end
  end

  // valid bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      valid_o <= '0;
    end else begin
      // sweep clears every way of one set
      if (flush_en_i) begin
        valid_q[flush_idx_i] <= '0;
      end else if (we_i) begin
        valid_q[index_i] <= valid_q[index_i] | way_oh_i;
      end
      // read output holds between lookups
      if (rd_i) begin
        valid_o <= valid_q[index_i];
      end
    end
  end

  // controller never fills while sweeping
  a_no_fill_in_flush : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(flush_en_i && we_i)
  );

endmodule

/* icache_top.sv */
//////////////////////////////////////////////////////////////////////
// instruction cache with victim buffer, connects controller and arrays
//////////////////////////////////////////////////////////////////////
module icache_top #(
  parameter int NUM_WAYS = icache_pkg::NUM_WAYS_DEF
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           en_i,
  input  logic                           flush_i,
  input  logic                           fetch_req_i,
  input  logic [icache_pkg::ADDR_W-1:0]  fetch_addr_i,
  input  logic                           mem_ack_i,
  input  icache_pkg::refill_t            mem_rtrn_i,
  output logic                           ready_o,
  output logic                           fetch_valid_o,
  output logic [icache_pkg::FETCH_W-1:0] fetch_data_o,
  output logic                           mem_req_o,
  output logic [icache_pkg::ADDR_W-1:0]  mem_addr_o,
  output logic                           miss_o
);
  import icache_pkg::*;

  logic                           lookup;
  logic [INDEX_W-1:0]             index;
  logic [TAG_W-1:0]               req_tag;
  logic [OFFSET_W-1:0]            offset;
  logic                           fill;
  line_t                          fill_line;
  logic                           flush_en;
  logic [NUM_WAYS-1:0][TAG_W-1:0] way_tags;
  logic [NUM_WAYS-1:0]            way_valid;
  line_t [NUM_WAYS-1:0]           way_lines;
  logic [NUM_WAYS-1:0]            tag_eq;
  logic [NUM_WAYS-1:0]            hit_vec;
  logic                           all_valid;
  logic [NUM_WAYS-1:0]            way_oh;
  line_t                          evict_line;
  logic [TAG_W-1:0]               evict_tag;
  logic                           victim_hit;
  line_t                          victim_line;
  logic                           victim_we;
  victim_entry_t                  victim_wr;
  logic [1:0]                     src_sel;

  // raw tag match per way, qualified by valid in the replace block
  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_cmp
    assign tag_eq[w] = (way_tags[w] == req_tag);
  end

  // tag and line of the way a refill would overwrite
  always_comb begin
    evict_line = '0;
    evict_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_oh[w]) begin
        evict_line = way_lines[w];
        evict_tag = way_tags[w];
      end
    end
  end

  icache_ctrl #(.NUM_WAYS(NUM_WAYS)) u_ctrl (
    .clk_i, .rst_ni, .en_i, .flush_i, .fetch_req_i, .fetch_addr_i,
    .hit_i(hit_vec), .all_valid_i(all_valid), .victim_hit_i(victim_hit),
    .victim_line_i(victim_line), .evict_line_i(evict_line), .evict_tag_i(evict_tag),
    .mem_ack_i, .mem_rtrn_i, .ready_o, .lookup_o(lookup), .index_o(index),
    .tag_o(req_tag), .offset_o(offset), .fill_o(fill), .fill_line_o(fill_line),
    .flush_en_o(flush_en), .victim_we_o(victim_we), .victim_wr_o(victim_wr),
    .fetch_valid_o, .src_sel_o(src_sel), .mem_req_o, .mem_addr_o, .miss_o
  );

  icache_tag_array #(.NUM_WAYS(NUM_WAYS)) u_tag_array (
    .clk_i, .rst_ni, .rd_i(lookup), .index_i(index), .flush_en_i(flush_en),
    .flush_idx_i(index), .we_i(fill), .way_oh_i(way_oh), .tag_i(req_tag),
    .tag_o(way_tags), .valid_o(way_valid)
  );

  icache_data_array #(.NUM_WAYS(NUM_WAYS)) u_data_array (
    .clk_i, .rd_i(lookup), .index_i(index), .we_i(fill), .way_oh_i(way_oh),
    .line_i(fill_line), .line_o(way_lines)
  );

  icache_replace #(.NUM_WAYS(NUM_WAYS)) u_replace (
    .clk_i, .rst_ni, .valid_i(way_valid), .hit_i(tag_eq), .advance_i(fill),
    .hit_o(hit_vec), .all_valid_o(all_valid), .way_oh_o(way_oh)
  );

  icache_victim_buffer u_victim (
    .clk_i, .rst_ni, .clear_i(flush_en), .lookup_tag_i(req_tag),
    .lookup_index_i(index), .we_i(victim_we), .entry_i(victim_wr),
    .hit_o(victim_hit), .line_o(victim_line)
  );

  icache_fetch_out #(.NUM_WAYS(NUM_WAYS)) u_fetch_out (
    .clk_i, .rst_ni, .hit_oh_i(hit_vec), .lines_i(way_lines),
    .victim_line_i(victim_line), .refill_line_i(mem_rtrn_i.line),
    .offset_i(offset), .src_sel_i(src_sel), .fetch_data_o
  );

endmodule

/* icache_victim_buffer.sv */
//////////////////////////////////////////////////////////////////////
// single entry holding the last line evicted from a full set
// looked up in parallel with the set, emptied by the flush sweep
//////////////////////////////////////////////////////////////////////
module icache_victim_buffer (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  input  logic [icache_pkg::TAG_W-1:0]    lookup_tag_i,
  input  logic [icache_pkg::INDEX_W-1:0]  lookup_index_i,
  input  logic                            we_i,
  input  icache_pkg::victim_entry_t       entry_i,
  output logic                            hit_o,
  output icache_pkg::line_t               line_o
);
  import icache_pkg::*;

  victim_entry_t entry_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      entry_q <= '0;
    end else if (clear_i) begin
      entry_q.valid <= 1'b0;
    end else if (we_i) begin
      // a swap may write an empty entry back
      entry_q <= entry_i;
    end
  end

  // full line address compare
  assign hit_o = entry_q.valid &&
                 (entry_q.tag == lookup_tag_i) &&
                 (entry_q.index == lookup_index_i);
  assign line_o = entry_q.line;

endmodule

/* sim.f */
icache_pkg.sv
icache_tag_array.sv
icache_data_array.sv
icache_replace.sv
icache_victim_buffer.sv
icache_ctrl.sv
icache_fetch_out.sv
icache_top.sv
tb_icache.sv

/* tb_icache.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the instruction cache, with a line memory model
// runs misses, hits, victim swaps, flushes and disabled-cache fetches
//////////////////////////////////////////////////////////////////////
module tb_icache;
  timeunit 1ns;
  timeprecision 1ps;
  import icache_pkg::*;

  localparam int NUM_WAYS = 4;
  localparam int WAIT_LIMIT = 200;
  localparam int WORDS = LINE_W / FETCH_W;
  // a line outside the conflict set
  localparam logic [31:0] LINE_A = 32'h0001_2340;

  logic        clk_i;
  logic        rst_ni;
  logic        en_i;
  logic        flush_i;
  logic        fetch_req_i;
  logic [31:0] fetch_addr_i;
  logic        mem_ack_i;
  refill_t     mem_rtrn_i;
  logic        ready_o;
  logic        fetch_valid_o;
  logic [31:0] fetch_data_o;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        miss_o;

  // shared between monitor, memory model and stimulus
  logic [31:0] accepted_q[$];
  int          accept_cyc_q[$];
  int          lat_q[$];
  int          cycle;
  int          valid_count;
  int          req_count;
  int          miss_count;
  int          error_count;
  logic [31:0] rand_state;

  icache_top #(.NUM_WAYS(NUM_WAYS)) u_dut (
    .clk_i, .rst_ni, .en_i, .flush_i, .fetch_req_i, .fetch_addr_i,
    .mem_ack_i, .mem_rtrn_i, .ready_o, .fetch_valid_o, .fetch_data_o,
    .mem_req_o, .mem_addr_o, .miss_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // memory content at a word address
  function automatic logic [31:0] mem_word(input logic [31:0] word_addr);
    return lcg_step(word_addr);
  endfunction

  // whole line for a line-aligned byte address, word 0 in the low bits
  function automatic line_t line_of(input logic [31:0] line_addr);
    line_t l;
    for (int w = 0; w < WORDS; w++) begin
      l[w*FETCH_W +: FETCH_W] = mem_word((line_addr >> 2) + 32'(w));
    end
    return l;
  endfunction

  // five lines that all map to set 9
  function automatic logic [31:0] conflict_addr(input int k);
    return 32'h0010_0090 + 32'(k) * 32'h100;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // error handling
  //////////////////////////////////////////////////////////////////////

  task automatic end_in_failure();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic flag_mismatch(input string what);
    error_count++;
    $display("CHECK FAILED at %0t ns: %s", $time, what);
    end_in_failure();
  endtask

  task automatic give_up(input string what);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, what);
    end_in_failure();
  endtask

  //////////////////////////////////////////////////////////////////////
  // response monitor, every word is checked against mem_word
  //////////////////////////////////////////////////////////////////////

  initial begin : response_monitor
    logic [31:0] acc_addr;
    logic [31:0] expected;
    int          acc_cyc;
    logic        req_seen;
    req_seen = 1'b0;
    forever begin
      @(negedge clk_i);
      cycle++;
      if (rst_ni) begin
        if (fetch_valid_o) begin
          assert (accepted_q.size() > 0)
            else give_up("fetch_valid_o pulsed with no fetch outstanding");
          acc_addr = accepted_q.pop_front();
          acc_cyc = accept_cyc_q.pop_front();
          expected = mem_word(acc_addr >> 2);
          assert (fetch_data_o === expected)
            else flag_mismatch($sformatf("fetch 0x%08h gave 0x%08h, expected 0x%08h",
                                         acc_addr, fetch_data_o, expected));
          lat_q.push_back(cycle - acc_cyc);
          valid_count++;
        end
        // accepted in this cycle
        if (ready_o && fetch_req_i) begin
          accepted_q.push_back(fetch_addr_i);
          accept_cyc_q.push_back(cycle);
        end
        if (mem_req_o && !req_seen) begin
          req_count++;
        end
        req_seen = mem_req_o;
        if (miss_o) begin
          miss_count++;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory model, ack then whole line after 1 to 6 cycles
  //////////////////////////////////////////////////////////////////////

  initial begin : memory_model
    logic [31:0] line_addr;
    logic [31:0] expected_line;
    int          delay;
    forever begin
      @(negedge clk_i);
      if (rst_ni && mem_req_o) begin
        line_addr = mem_addr_o;
        assert (accepted_q.size() > 0)
          else give_up("memory request with no fetch outstanding");
        expected_line = accepted_q[0] & ~32'hF;
        assert (line_addr === expected_line)
          else flag_mismatch($sformatf("mem_addr_o 0x%08h, expected 0x%08h",
                                       line_addr, expected_line));
        @(posedge clk_i);
        mem_ack_i <= 1'b1;
        @(posedge clk_i);
        mem_ack_i <= 1'b0;
        rand_state = lcg_step(rand_state);
        delay = 1 + int'((rand_state >> 16) % 6);
        repeat (delay - 1) @(posedge clk_i);
        mem_rtrn_i <= '{valid: 1'b1, line: line_of(line_addr)};
        @(posedge clk_i);
        mem_rtrn_i <= '0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // back to back fetches, returns once every word has come back
  task automatic run_fetches(input logic [31:0] addrs[$]);
    int base;
    int waited;
    base = valid_count;
    for (int i = 0; i < addrs.size(); i++) begin
      @(posedge clk_i);
      fetch_req_i <= 1'b1;
      fetch_addr_i <= addrs[i];
      waited = 0;
      @(negedge clk_i);
      while (!ready_o) begin
        waited++;
        assert (waited < WAIT_LIMIT) else give_up("cache never accepted a fetch");
        @(negedge clk_i);
      end
    end
    @(posedge clk_i);
    fetch_req_i <= 1'b0;
    waited = 0;
    while (valid_count < base + addrs.size()) begin
      waited++;
      assert (waited < WAIT_LIMIT) else give_up("fetched word never came back");
      @(posedge clk_i);
    end
  endtask

  // ready_o must stay low for a whole sweep with no output pulse
  task automatic wait_ready_after_flush(input string when_txt);
    int low_cycles;
    low_cycles = 0;
    @(negedge clk_i);
    while (!ready_o) begin
      assert (!fetch_valid_o && !mem_req_o && !miss_o)
        else flag_mismatch($sformatf("output pulse during flush %s", when_txt));
      low_cycles++;
      assert (low_cycles < WAIT_LIMIT) else give_up("ready_o never rose after a flush");
      @(negedge clk_i);
    end
    assert (low_cycles >= NUM_SETS)
      else flag_mismatch($sformatf("ready_o low %0d cycles %s, expected %0d or more",
                                   low_cycles, when_txt, NUM_SETS));
  endtask

  task automatic check_counts(input int reqs, input int misses, input string step);
    assert (req_count == reqs)
      else flag_mismatch($sformatf("%s: %0d memory requests, expected %0d",
                                   step, req_count, reqs));
    assert (miss_count == misses)
      else flag_mismatch($sformatf("%s: %0d miss pulses, expected %0d",
                                   step, miss_count, misses));
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] addrs[$];
    rst_ni = 1'b0;
    en_i = 1'b1;
    flush_i = 1'b0;
    fetch_req_i = 1'b0;
    fetch_addr_i = '0;
    mem_ack_i = 1'b0;
    mem_rtrn_i = '0;
    rand_state = 32'd32;

    // reset, then the power-up sweep
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      assert (!ready_o && !fetch_valid_o && !mem_req_o && !miss_o)
        else flag_mismatch("output active during reset");
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;
    wait_ready_after_flush("after reset");

    // first fetch of a line misses once
    addrs = {LINE_A + 32'h8};
    run_fetches(addrs);
    check_counts(1, 1, "first fetch");

    // rest of the line, one-cycle hits
    lat_q.delete();
    addrs = {LINE_A, LINE_A + 32'h4, LINE_A + 32'hC};
    run_fetches(addrs);
    check_counts(1, 1, "same line");
    foreach (lat_q[i]) begin
      assert (lat_q[i] == 1)
        else flag_mismatch($sformatf("hit %0d latency %0d, expected 1", i, lat_q[i]));
    end

    // five lines in one set, four ways plus the victim buffer
    addrs.delete();
    for (int k = 0; k < 5; k++) begin
      addrs.push_back(conflict_addr(k) + 32'(k % WORDS) * 32'h4);
    end
    run_fetches(addrs);
    check_counts(6, 6, "conflict fill");
    lat_q.delete();
    addrs.delete();
    for (int k = 4; k >= 0; k--) begin
      addrs.push_back(conflict_addr(k) + 32'((k + 1) % WORDS) * 32'h4);
    end
    run_fetches(addrs);
    check_counts(6, 6, "conflict refetch");
    foreach (lat_q[i]) begin
      assert (lat_q[i] == 1 || lat_q[i] == 2)
        else flag_mismatch($sformatf("refetch %0d latency %0d", i, lat_q[i]));
    end

    // flush empties the cache
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    wait_ready_after_flush("after flush_i");
    addrs = {conflict_addr(0)};
    run_fetches(addrs);
    check_counts(7, 7, "after flush");

    // disabled cache goes to memory without a miss pulse
    @(posedge clk_i);
    en_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    addrs = {conflict_addr(0) + 32'h4, LINE_A + 32'h4, conflict_addr(0) + 32'h4};
    run_fetches(addrs);
    check_counts(10, 7, "disabled");

    // switching on passes through a flush
    @(posedge clk_i);
    en_i <= 1'b1;
    wait_ready_after_flush("after enable");
    addrs = {conflict_addr(0)};
    run_fetches(addrs);
    check_counts(11, 8, "re-enabled");

    @(posedge clk_i);
    if (error_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      end_in_failure();
    end
  end

endmodule
